// ==== include/pipe_defines.svh ====
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// ****************************************
// datapath sizes
// ****************************************

`define NB_DATA     32                     // width of operands, results and memory words
`define NB_REG      5                      // register index width for 32 registers

// ****************************************
// data memory
// ****************************************

`define DMEM_AW     6                      // word address bits
`define DMEM_DEPTH  (1 << `DMEM_AW)        // number of words in the data memory

`endif

// ==== list.f ====
+incdir+include
verilog/alu_pkg.sv
verilog/stage_pkg.sv
verilog/execute_stage.sv
verilog/ex_mem_reg.sv
verilog/mem_stage.sv
verilog/mem_wb_reg.sv
verilog/exec_mem_top.sv
tests/tb_exec_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, then judge the run from the log
rm -f sim.log
verilator --binary --top-module tb_exec_mem -f list.f -o tb_exec_mem \
    && ./obj_dir/tb_exec_mem > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^PASS: all tests$" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/pipe_input.txt ====
# halt alu_op op_a op_b store_data rd rt reg_dst mem2reg mem_write reg_write width sign rnd
# then expected reg_write write_reg data, all hex; halt lines hold the bundle; rnd 1 draws op_a, op_b
0 0 00000005 00000003 00000000 01 02 0 0 0 1 3 0 0 1 01 00000008
0 1 00000003 00000005 00000000 03 04 1 0 0 1 3 0 0 1 04 fffffffe
0 2 f0f0f0f0 ff00ff00 00000000 05 06 0 0 0 1 3 0 0 1 05 f000f000
0 3 f0f0f0f0 0f0f0000 00000000 07 08 1 0 0 1 3 0 0 1 08 fffff0f0
0 4 aaaaaaaa ffff0000 00000000 09 0a 0 0 0 1 3 0 0 1 09 5555aaaa
0 5 0000ffff 00ff0000 00000000 0b 0c 1 0 0 1 3 0 0 1 0c ff000000
0 6 ffffffff 00000001 00000000 0d 0e 0 0 0 1 3 0 0 1 0d 00000001
0 7 ffffffff 00000001 00000000 0e 0f 1 0 0 1 3 0 0 1 0f 00000000
0 8 00000003 00000024 00000000 10 11 0 0 0 1 3 0 0 1 10 00000030
0 9 80000000 00000004 00000000 11 12 1 0 0 1 3 0 0 1 12 08000000
0 a 80000000 00000004 00000000 13 14 0 0 0 1 3 0 0 1 13 f8000000
0 b 00000000 1234abcd 00000000 14 15 1 0 0 1 3 0 0 1 15 abcd0000
0 0 00000000 00000000 00000000 16 17 0 0 0 1 3 0 1 1 16 00000000
0 1 00000000 00000000 00000000 18 19 1 0 0 1 3 0 1 1 19 00000000
0 6 00000000 00000000 00000000 1a 1b 0 0 0 1 3 0 1 1 1a 00000000
0 7 00000000 00000000 00000000 1e 1f 0 0 0 1 3 0 1 1 1e 00000000
0 a 00000000 00000000 00000000 1c 1d 1 0 0 1 3 0 1 1 1d 00000000
0 0 00000040 00000000 8badf00d 00 00 0 0 1 0 3 0 0 0 00 00000040
0 0 00000040 00000000 00000000 00 02 1 1 0 1 3 0 0 1 02 8badf00d
0 0 00000044 00000001 123456a5 00 00 0 0 1 0 0 0 0 0 00 00000045
0 0 00000044 00000001 00000000 03 00 0 1 0 1 0 1 0 1 03 ffffffa5
0 0 00000044 00000001 00000000 04 00 0 1 0 1 0 0 0 1 04 000000a5
0 0 00000048 00000002 9876c3b1 00 00 0 0 1 0 1 0 0 0 00 0000004a
0 0 00000048 00000002 00000000 06 00 0 1 0 1 1 1 0 1 06 ffffc3b1
0 0 00000048 00000002 00000000 07 00 0 1 0 1 1 0 0 1 07 0000c3b1
0 0 00000050 00000001 0000003c 00 00 0 0 1 0 0 0 0 0 00 00000051
1 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 0 00 00000000
1 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 0 00 00000000
1 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 0 00 00000000
0 0 00000050 00000000 00000000 0b 00 0 1 0 1 3 0 0 1 0b 00003c00
0 0 00000007 00000009 00000000 0d 00 0 0 0 1 3 0 0 1 0d 00000010
1 0 00000000 00000000 00000000 00 00 0 0 0 0 0 0 0 0 00 00000000
0 0 00000000 00000000 00000000 00 00 0 0 0 0 3 0 0 0 00 00000000
0 0 00000000 00000000 00000000 00 00 0 0 0 0 3 0 0 0 00 00000000

// ==== tests/tb_exec_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module tb_exec_mem
    import alu_pkg::*;
    import stage_pkg::*;
();

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 16;
    localparam int    NUM_FIELDS   = 17;
    localparam string VEC_FILE     = "tests/pipe_input.txt";

    logic   clk;
    logic   i_reset;
    logic   i_halt;
    idex_t  i_idex;
    wb_t    o_wb;

    idex_t  vec_idex [$];
    logic   vec_halt [$];
    wb_t    vec_exp  [$];
    wb_t    exp_q    [2];                     // entry 0 sits in EX/MEM, entry 1 in write-back
    logic   val_q    [2];
    int     line_q   [2];
    int     errors;
    int     seed;
    logic   loaded;

    exec_mem_top uut (
        .clk     (clk),
        .i_reset (i_reset),
        .i_halt  (i_halt),
        .i_idex  (i_idex),
        .o_wb    (o_wb)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // ****************************************
    // reference model and checks
    // ****************************************

    function automatic logic [`NB_DATA-1:0] alu_model(alu_op_e op, logic [31:0] a, logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] fill;
        sh   = b[4:0];
        fill = a[31] ? ~(32'hffffffff >> sh) : 32'h0;   // sign bits shifted in from the left
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a + ~b + 32'd1;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_nor:  return ~a & ~b;
            alu_slt:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            alu_sltu: return {31'b0, a < b};
            alu_sll:  return a << sh;
            alu_srl:  return a >> sh;
            alu_sra:  return (a >> sh) | fill;
            alu_lui:  return {b[15:0], 16'h0000};
            default:  return 32'h0;
        endcase
    endfunction

    task automatic check_wb(input wb_t got, input wb_t want, input int vec);
        if (got.reg_write !== want.reg_write) begin
            errors++;
            $display("Fail o_wb.reg_write (vector %0d): got %h expected %h",
                     vec, got.reg_write, want.reg_write);
        end
        if (got.write_reg !== want.write_reg) begin
            errors++;
            $display("Fail o_wb.write_reg (vector %0d): got %h expected %h",
                     vec, got.write_reg, want.write_reg);
        end
        if (got.data !== want.data) begin
            errors++;
            $display("Fail o_wb.data (vector %0d): got %h expected %h", vec, got.data, want.data);
        end
    endtask

    // nothing has reached write-back yet
    task automatic check_idle(input wb_t got);
        if (got.reg_write !== 1'b0) begin
            errors++;
            $display("Fail o_wb.reg_write (idle): got %h expected 0", got.reg_write);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       text;
        logic [31:0] v [NUM_FIELDS];
        idex_t       idex;
        wb_t         want;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the vector file %s", VEC_FILE);
            return;
        end
        while ($fgets(text, fd) != 0) begin
            if (text.len() < 2 || text.getc(0) == "#") continue;
            n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                        v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
            if (n != NUM_FIELDS) begin
                errors++;
                $display("a vector line has %0d fields instead of %0d", n, NUM_FIELDS);
            end else begin
                idex.alu_op     = alu_op_e'(v[1][3:0]);
                idex.op_a       = v[2];
                idex.op_b       = v[3];
                idex.store_data = v[4];
                idex.rd         = v[5][`NB_REG-1:0];
                idex.rt         = v[6][`NB_REG-1:0];
                idex.reg_dst    = v[7][0];
                idex.mem2reg    = v[8][0];
                idex.mem_write  = v[9][0];
                idex.reg_write  = v[10][0];
                idex.width      = mem_width_e'(v[11][1:0]);
                idex.sign_flag  = v[12][0];
                want.reg_write  = v[14][0];
                want.write_reg  = v[15][`NB_REG-1:0];
                want.data       = v[16];
                if (v[13][0]) begin                      // random operands replace the file values
                    idex.op_a = $random(seed);
                    idex.op_b = $random(seed);
                    want.data = alu_model(idex.alu_op, idex.op_a, idex.op_b);
                end
                vec_halt.push_back(v[0][0]);
                vec_idex.push_back(idex);
                vec_exp.push_back(want);
            end
        end
        $fclose(fd);
    endtask

    // ****************************************
    // stimulus
    // ****************************************

    initial begin : main
        clk     = 1'b0;
        i_reset = 1'b0;
        i_halt  = 1'b0;
        i_idex  = '0;
        errors  = 0;
        seed    = 32'hc3905c0f;
        loaded  = 1'b0;
        for (int i = 0; i < 2; i++) begin
            exp_q[i]  = '0;
            val_q[i]  = 1'b0;
            line_q[i] = 0;
        end
        load_vectors();
        if (vec_idex.size() == 0) begin
            errors++;
            $display("no test vectors were read");
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        check_idle(o_wb);
        i_reset = 1'b1;
        for (int n = 0; n < vec_idex.size(); n++) begin
            i_halt = vec_halt[n];
            if (!vec_halt[n]) begin
                i_idex = vec_idex[n];                    // while halted the source holds its bundle
            end
            @(posedge clk);
            #1;
            if (!i_halt) begin                           // the pipeline moves one slot
                exp_q[1]  = exp_q[0];
                val_q[1]  = val_q[0];
                line_q[1] = line_q[0];
                exp_q[0]  = vec_exp[n];
                val_q[0]  = 1'b1;
                line_q[0] = n;
            end
            if (val_q[1]) begin
                check_wb(o_wb, exp_q[1], line_q[1]);
            end else begin
                check_idle(o_wb);
            end
            #1;
        end
        $display("errors: %0d over %0d vectors", errors, vec_idex.size());
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        #((vec_idex.size() + 40) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", vec_idex.size() + 40);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    localparam int unsigned SHAMT_W = 5;   // shift amount comes from the low bits of op_b

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_nor  = 4'd5,
        alu_slt  = 4'd6,                   // signed compare
        alu_sltu = 4'd7,                   // unsigned compare
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11                   // immediate into the upper half
    } alu_op_e;

    typedef enum logic [1:0] {
        width_byte = 2'b00,
        width_half = 2'b01,
        width_word = 2'b11                 // also the value after reset
    } mem_width_e;

endpackage

`default_nettype wire

// ==== verilog/ex_mem_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module ex_mem_reg
    import alu_pkg::*;
    import stage_pkg::*;
(
    input  wire             clk,
    input  wire             i_reset,
    input  wire             i_halt,
    input  wire exmem_in_t  i_exmem,
    output exmem_t          o_exmem
);

    // rt is the destination of immediate forms and rd that of register forms
    logic [`NB_REG-1:0]     next_write_reg;

    assign next_write_reg = i_exmem.reg_dst ? i_exmem.rt : i_exmem.rd;

    always_ff @(posedge clk or negedge i_reset) begin
        if (!i_reset) begin
            o_exmem.mem2reg   <= 1'b0;
            o_exmem.mem_write <= 1'b0;
            o_exmem.reg_write <= 1'b0;
            o_exmem.width     <= width_word;
            o_exmem.sign_flag <= 1'b0;
            o_exmem.result    <= '0;
            o_exmem.data4mem  <= '0;
            o_exmem.write_reg <= '0;
        end else if (!i_halt) begin                                 // halt freezes the stage
            o_exmem.mem2reg   <= i_exmem.mem2reg;
            o_exmem.mem_write <= i_exmem.mem_write;
            o_exmem.reg_write <= i_exmem.reg_write;
            o_exmem.width     <= i_exmem.width;
            o_exmem.sign_flag <= i_exmem.sign_flag;
            o_exmem.result    <= i_exmem.result;
            o_exmem.data4mem  <= i_exmem.data4mem;
            o_exmem.write_reg <= next_write_reg;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/exec_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module exec_mem_top
    import stage_pkg::*;
(
    input  wire             clk,
    input  wire             i_reset,
    input  wire             i_halt,
    input  wire idex_t      i_idex,
    output wb_t             o_wb
);

    exmem_in_t              ex_cand;        // unregistered EX result
    exmem_t                 exmem;          // EX/MEM register contents
    logic [`NB_DATA-1:0]    load_data;

    execute_stage u_execute (
        .i_idex      (i_idex),
        .o_exmem     (ex_cand)
    );

    ex_mem_reg u_ex_mem (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_halt      (i_halt),
        .i_exmem     (ex_cand),
        .o_exmem     (exmem)
    );

    mem_stage u_mem (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_halt      (i_halt),
        .i_exmem     (exmem),
        .o_load_data (load_data)
    );

    mem_wb_reg u_mem_wb (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_halt      (i_halt),
        .i_exmem     (exmem),
        .i_load_data (load_data),
        .o_wb        (o_wb)
    );

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module execute_stage
    import alu_pkg::*;
    import stage_pkg::*;
(
    input  wire idex_t      i_idex,
    output exmem_in_t       o_exmem
);

    logic [`NB_DATA-1:0]    alu_result;
    logic [SHAMT_W-1:0]     shamt;
    logic                   lt_signed;
    logic                   lt_unsigned;

    assign shamt       = i_idex.op_b[SHAMT_W-1:0];                 // only the low five bits shift
    assign lt_signed   = $signed(i_idex.op_a) < $signed(i_idex.op_b);
    assign lt_unsigned = i_idex.op_a < i_idex.op_b;

    // ****************************************
    // ALU
    // ****************************************

    always_comb begin
        case (i_idex.alu_op)
            alu_add:  alu_result = i_idex.op_a + i_idex.op_b;
            alu_sub:  alu_result = i_idex.op_a - i_idex.op_b;
            alu_and:  alu_result = i_idex.op_a & i_idex.op_b;
            alu_or:   alu_result = i_idex.op_a | i_idex.op_b;
            alu_xor:  alu_result = i_idex.op_a ^ i_idex.op_b;
            alu_nor:  alu_result = ~(i_idex.op_a | i_idex.op_b);
            alu_slt:  alu_result = {{(`NB_DATA-1){1'b0}}, lt_signed};
            alu_sltu: alu_result = {{(`NB_DATA-1){1'b0}}, lt_unsigned};
            alu_sll:  alu_result = i_idex.op_a << shamt;
            alu_srl:  alu_result = i_idex.op_a >> shamt;
            alu_sra:  alu_result = $signed(i_idex.op_a) >>> shamt;   // keeps the sign bit
            alu_lui:  alu_result = {i_idex.op_b[15:0], 16'h0000};
            default:  alu_result = '0;                               // unused encodings give zero
        endcase
    end

    // candidate record that ex_mem_reg registers
    always_comb begin
        o_exmem.mem2reg   = i_idex.mem2reg;
        o_exmem.mem_write = i_idex.mem_write;
        o_exmem.reg_write = i_idex.reg_write;
        o_exmem.width     = i_idex.width;
        o_exmem.sign_flag = i_idex.sign_flag;
        o_exmem.result    = alu_result;
        o_exmem.data4mem  = i_idex.store_data;
        o_exmem.rd        = i_idex.rd;
        o_exmem.rt        = i_idex.rt;
        o_exmem.reg_dst   = i_idex.reg_dst;
    end

endmodule

`default_nettype wire

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module mem_stage
    import alu_pkg::*;
    import stage_pkg::*;
(
    input  wire                 clk,
    input  wire                 i_reset,
    input  wire                 i_halt,
    input  wire exmem_t         i_exmem,
    output logic [`NB_DATA-1:0] o_load_data
);

    logic [`NB_DATA-1:0]    mem [`DMEM_DEPTH];
    logic [`DMEM_AW-1:0]    word_addr;
    logic [1:0]             lane;
    logic [3:0]             byte_en;
    logic [`NB_DATA-1:0]    wr_data;
    logic [`NB_DATA-1:0]    rd_word;
    logic [7:0]             rd_byte;
    logic [15:0]            rd_half;

    assign word_addr = i_exmem.result[`DMEM_AW+1:2];    // byte address to word index
    assign lane      = i_exmem.result[1:0];

    // ****************************************
    // store path
    // ****************************************

    // store data is replicated so each lane sees its own copy
    always_comb begin
        case (i_exmem.width)
            width_byte: begin
                byte_en = 4'b0001 << lane;
                wr_data = {4{i_exmem.data4mem[7:0]}};
            end
            width_half: begin
                byte_en = lane[1] ? 4'b1100 : 4'b0011;     // bit 0 of the lane is ignored
                wr_data = {2{i_exmem.data4mem[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wr_data = i_exmem.data4mem;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_reset) begin
        if (!i_reset) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (i_exmem.mem_write && !i_halt) begin   // a halted store commits once after release
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[word_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // ****************************************
    // load path with asynchronous read
    // ****************************************

    assign rd_word = mem[word_addr];
    assign rd_byte = rd_word[lane*8 +: 8];
    assign rd_half = lane[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        case (i_exmem.width)
            width_byte: o_load_data = {{(`NB_DATA-8){i_exmem.sign_flag & rd_byte[7]}}, rd_byte};
            width_half: o_load_data = {{(`NB_DATA-16){i_exmem.sign_flag & rd_half[15]}}, rd_half};
            default:    o_load_data = rd_word;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/mem_wb_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module mem_wb_reg
    import stage_pkg::*;
(
    input  wire                 clk,
    input  wire                 i_reset,
    input  wire                 i_halt,
    input  wire exmem_t         i_exmem,
    input  wire [`NB_DATA-1:0]  i_load_data,
    output wb_t                 o_wb
);

    logic [`NB_DATA-1:0]    wb_sel;
    logic                   wb_reg_write;
    logic [`NB_REG-1:0]     wb_write_reg;
    logic [`NB_DATA-1:0]    wb_data;

    assign wb_sel = i_exmem.mem2reg ? i_load_data : i_exmem.result;   // loads take memory data

    // write enable of the write-back record
    always_ff @(posedge clk or negedge i_reset) begin
        if (!i_reset) begin
            wb_reg_write <= 1'b0;
        end else if (!i_halt) begin
            wb_reg_write <= i_exmem.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_halt) begin
            wb_write_reg <= i_exmem.write_reg;
            wb_data      <= wb_sel;
        end
    end

    assign o_wb = '{reg_write: wb_reg_write, write_reg: wb_write_reg, data: wb_data};

endmodule

`default_nettype wire

// ==== verilog/stage_pkg.sv ====
`default_nettype none

`include "pipe_defines.svh"

package stage_pkg;

    import alu_pkg::*;

    // ****************************************
    // records passed between pipeline stages
    // ****************************************

    typedef struct packed {
        alu_op_e                alu_op;
        logic [`NB_DATA-1:0]    op_a;
        logic [`NB_DATA-1:0]    op_b;
        logic [`NB_DATA-1:0]    store_data;    // rt value already read by decode
        logic [`NB_REG-1:0]     rd;
        logic [`NB_REG-1:0]     rt;
        logic                   reg_dst;       // set selects rt as destination
        logic                   mem2reg;
        logic                   mem_write;
        logic                   reg_write;
        mem_width_e             width;
        logic                   sign_flag;     // sign extend byte and half loads
    } idex_t;

    typedef struct packed {
        logic                   mem2reg;
        logic                   mem_write;
        logic                   reg_write;
        mem_width_e             width;
        logic                   sign_flag;
        logic [`NB_DATA-1:0]    result;
        logic [`NB_DATA-1:0]    data4mem;
        logic [`NB_REG-1:0]     rd;
        logic [`NB_REG-1:0]     rt;
        logic                   reg_dst;       // destination resolved in the EX/MEM register
    } exmem_in_t;

    typedef struct packed {
        logic                   mem2reg;
        logic                   mem_write;
        logic                   reg_write;
        mem_width_e             width;
        logic                   sign_flag;
        logic [`NB_DATA-1:0]    result;        // ALU result that is also the memory byte address
        logic [`NB_DATA-1:0]    data4mem;
        logic [`NB_REG-1:0]     write_reg;
    } exmem_t;

    typedef struct packed {
        logic                   reg_write;
        logic [`NB_REG-1:0]     write_reg;
        logic [`NB_DATA-1:0]    data;
    } wb_t;

endpackage

`default_nettype wire
